// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = flip_manager_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== logic/energy_fifo_maintainer.sv ====
/*
 * Best energy tracking with a single output slot.
 * Best energy starts from the most positive value on each cmpt_en_i pulse.
 * Equal energy counts as worse and gives a none push.
 */
`timescale 1ns/1ps
`default_nettype none

module energy_fifo_maintainer (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              en_i,
    input  wire logic              flush_i,
    input  wire logic              cmpt_en_i,
    input  wire logic              en_comparison_i,
    input  wire logic              cmpt_idle_i,
    input  wire logic              energy_valid_i,
    input  wire flip_pkg::energy_t energy_i,
    input  wire flip_pkg::spin_t   spin_i,
    output logic                   energy_ready_o,
    spin_push_if.source            src_push
);

    logic slot_valid_q;
    logic slot_none_q;
    flip_pkg::spin_t slot_spin_q;
    flip_pkg::energy_t best_q;

    logic energy_fire;
    logic push_fire;
    logic better;

    // Accept only with an empty slot and a computation running
    assign energy_ready_o = en_i & ~slot_valid_q & ~cmpt_idle_i;
    assign energy_fire = energy_valid_i & energy_ready_o;
    assign push_fire = src_push.valid & src_push.ready;

    // Strictly lower wins
    assign better = (energy_i < best_q);

    assign src_push.valid = slot_valid_q;
    assign src_push.spin = slot_spin_q;
    assign src_push.none = slot_none_q;

    // Slot occupancy and best energy
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot_valid_q <= 1'b0;
            best_q <= flip_pkg::ENERGY_MAX;
        end else if (flush_i) begin
            slot_valid_q <= 1'b0;
            best_q <= flip_pkg::ENERGY_MAX;
        end else if (en_i) begin
            if (energy_fire) begin
                slot_valid_q <= 1'b1;
            end else if (push_fire) begin
                slot_valid_q <= 1'b0;
            end
            if (cmpt_en_i && cmpt_idle_i) begin
                best_q <= flip_pkg::ENERGY_MAX;
            end else if (energy_fire && en_comparison_i && better) begin
                best_q <= energy_i;
            end
        end
    end

    // Slot payload
    // Without comparison every spin is a real push
    always_ff @(posedge clk_i) begin
        if (en_i && energy_fire) begin
            slot_spin_q <= spin_i;
            slot_none_q <= en_comparison_i & ~better;
        end
    end

endmodule

`default_nettype wire

// ==== logic/flip_controller.sv ====
/*
 * Computation phase FSM and push arbiter in front of the spin FIFO.
 * Host pushes are accepted only in CMPT_IDLE, energy pushes only outside it.
 */
`timescale 1ns/1ps
`default_nettype none

module flip_controller (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            en_i,
    input  wire logic            flush_i,
    input  wire logic            cmpt_en_i,
    input  wire logic            icon_finish_i,
    input  wire logic            spin_configure_valid_i,
    input  wire logic            spin_configure_push_none_i,
    input  wire flip_pkg::spin_t spin_configure_i,
    output logic                 spin_configure_ready_o,
    spin_push_if.sink            src_push,
    spin_push_if.source          fifo_push,
    output logic                 cmpt_idle_o
);

    flip_pkg::cmpt_state_t state_q;
    flip_pkg::cmpt_state_t state_d;
    logic fifo_fire;

    assign fifo_fire = fifo_push.valid & fifo_push.ready;
    assign cmpt_idle_o = (state_q == flip_pkg::CMPT_IDLE);

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            flip_pkg::CMPT_IDLE: if (cmpt_en_i) state_d = flip_pkg::CMPT_BUSY;
            // Last icon output accepted downstream
            flip_pkg::CMPT_BUSY: if (icon_finish_i) state_d = flip_pkg::CMPT_WAIT_LAST;
            // Final energy returned and pushed back
            flip_pkg::CMPT_WAIT_LAST: if (fifo_fire) state_d = flip_pkg::CMPT_IDLE;
            default: state_d = flip_pkg::CMPT_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= flip_pkg::CMPT_IDLE;
        end else if (flush_i) begin
            state_q <= flip_pkg::CMPT_IDLE;
        end else if (en_i) begin
            state_q <= state_d;
        end
    end

    // Push source select
    // Idle routes the host, otherwise the energy maintainer
    always_comb begin
        if (cmpt_idle_o) begin
            fifo_push.valid = spin_configure_valid_i;
            fifo_push.spin = spin_configure_i;
            fifo_push.none = spin_configure_push_none_i;
            spin_configure_ready_o = fifo_push.ready;
            src_push.ready = 1'b0;
        end else begin
            fifo_push.valid = src_push.valid;
            fifo_push.spin = src_push.spin;
            fifo_push.none = src_push.none;
            spin_configure_ready_o = 1'b0;
            src_push.ready = fifo_push.ready;
        end
    end

endmodule

`default_nettype wire

// ==== logic/flip_engine.sv ====
/*
 * Flips FIFO spins with icons read from an external memory of one cycle latency.
 * Compute mode holds one base spin at a time, output valid two cycles after a take.
 * Readout mode passes spins unflipped with one cycle latency and no icon reads.
 */
`timescale 1ns/1ps
`default_nettype none

module flip_engine (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire logic                 en_i,
    input  wire logic                 flush_i,
    input  wire logic                 cmpt_en_i,
    input  wire logic                 cmpt_idle_i,
    input  wire logic                 host_readout_i,
    input  wire logic                 flip_disable_i,
    input  wire logic                 prev_valid_i,
    input  wire flip_pkg::spin_t      prev_spin_i,
    output logic                      prev_ready_o,
    output logic                      flipped_valid_o,
    output flip_pkg::spin_t           flipped_spin_o,
    input  wire logic                 flipped_ready_i,
    output logic                      flip_ren_o,
    output flip_pkg::icon_addr_t      flip_raddr_o,
    input  wire flip_pkg::spin_t      flip_rdata_i,
    input  wire flip_pkg::icon_addr_t icon_last_raddr_plus_one_i,
    output logic                      icon_finish_o
);

    flip_pkg::icon_addr_t addr_q;
    flip_pkg::spin_t base_q;
    flip_pkg::spin_t out_q;
    logic pend_q;
    logic pend_last_q;
    logic out_valid_q;
    logic out_last_q;

    logic compute_mode;
    logic readout_mode;
    logic take;
    logic out_take;
    logic addr_is_last;

    // Compute stops once all icon addresses are used
    assign compute_mode = ~cmpt_idle_i & (addr_q < icon_last_raddr_plus_one_i);
    assign readout_mode = cmpt_idle_i & host_readout_i;
    assign addr_is_last = (flip_pkg::icon_addr_t'(addr_q + 1'b1) == icon_last_raddr_plus_one_i);

    assign out_take = out_valid_q & flipped_ready_i;

    // Compute waits for an empty output; readout may stream
    always_comb begin
        prev_ready_o = 1'b0;
        if (en_i && !pend_q) begin
            if (compute_mode) begin
                prev_ready_o = ~out_valid_q;
            end else if (readout_mode) begin
                prev_ready_o = ~out_valid_q | flipped_ready_i;
            end
        end
    end

    assign take = prev_valid_i & prev_ready_o;

    // Icon read in the same cycle as the take
    assign flip_ren_o = take & compute_mode;
    assign flip_raddr_o = addr_q;

    assign flipped_valid_o = out_valid_q;
    assign flipped_spin_o = out_q;
    assign icon_finish_o = out_take & out_last_q;

    // Address counter and pipeline flags
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            addr_q <= '0;
            pend_q <= 1'b0;
            pend_last_q <= 1'b0;
            out_valid_q <= 1'b0;
            out_last_q <= 1'b0;
        end else if (flush_i) begin
            addr_q <= '0;
            pend_q <= 1'b0;
            pend_last_q <= 1'b0;
            out_valid_q <= 1'b0;
            out_last_q <= 1'b0;
        end else if (en_i) begin
            if (cmpt_en_i && cmpt_idle_i) begin
                addr_q <= '0;
            end else if (flip_ren_o) begin
                addr_q <= addr_q + 1'b1;
            end
            // Icon data arrives while pend_q is high
            pend_q <= flip_ren_o;
            if (flip_ren_o) pend_last_q <= addr_is_last;
            if (pend_q || (take && readout_mode)) begin
                out_valid_q <= 1'b1;
                out_last_q <= pend_q & pend_last_q;
            end else if (out_take) begin
                out_valid_q <= 1'b0;
                out_last_q <= 1'b0;
            end
        end
    end

    // Base spin and output register
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (flip_ren_o) base_q <= prev_spin_i;
            if (pend_q) begin
                out_q <= flip_disable_i ? base_q : (base_q ^ flip_rdata_i);
            end else if (take && readout_mode) begin
                out_q <= prev_spin_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/flip_manager.sv ====
/*
 * Spin flip manager top with plain ports.
 * Host loads spins only while cmpt_idle_o is high; readout uses spin_pop_*.
 * Energy returns are expected only for spins sent out on spin_pop_*.
 */
`timescale 1ns/1ps
`default_nettype none

module flip_manager (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire logic                 en_i,
    input  wire logic                 flush_i,
    input  wire logic                 en_comparison_i,

    // Computation control
    input  wire logic                 cmpt_en_i,
    output logic                      cmpt_idle_o,
    input  wire logic                 host_readout_i,

    // Host configuration pushes
    input  wire logic                 spin_configure_valid_i,
    input  wire flip_pkg::spin_t      spin_configure_i,
    input  wire logic                 spin_configure_push_none_i,
    output logic                      spin_configure_ready_o,

    // Flipped or read out spins
    output logic                      spin_pop_valid_o,
    output flip_pkg::spin_t           spin_pop_o,
    input  wire logic                 spin_pop_ready_i,

    // Energy returns
    input  wire logic                 energy_valid_i,
    output logic                      energy_ready_o,
    input  wire flip_pkg::energy_t    energy_i,
    input  wire flip_pkg::spin_t      spin_i,

    // Icon memory
    output logic                      flip_ren_o,
    output flip_pkg::icon_addr_t      flip_raddr_o,
    input  wire flip_pkg::icon_addr_t icon_last_raddr_plus_one_i,
    input  wire flip_pkg::spin_t      flip_rdata_i,

    input  wire logic                 flip_disable_i
);

    // Energy maintainer to controller, controller to FIFO
    spin_push_if src_push ();
    spin_push_if fifo_push ();

    // FIFO pop towards the engine
    logic pop_valid;
    flip_pkg::spin_t pop_spin;
    logic pop_ready;

    logic icon_finish;

    flip_controller u_flip_controller (
        .clk_i                      (clk_i),
        .rst_n_i                    (rst_n_i),
        .en_i                       (en_i),
        .flush_i                    (flush_i),
        .cmpt_en_i                  (cmpt_en_i),
        .icon_finish_i              (icon_finish),
        .spin_configure_valid_i     (spin_configure_valid_i),
        .spin_configure_push_none_i (spin_configure_push_none_i),
        .spin_configure_i           (spin_configure_i),
        .spin_configure_ready_o     (spin_configure_ready_o),
        .src_push                   (src_push),
        .fifo_push                  (fifo_push),
        .cmpt_idle_o                (cmpt_idle_o)
    );

    energy_fifo_maintainer u_energy_fifo_maintainer (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .en_i            (en_i),
        .flush_i         (flush_i),
        .cmpt_en_i       (cmpt_en_i),
        .en_comparison_i (en_comparison_i),
        .cmpt_idle_i     (cmpt_idle_o),
        .energy_valid_i  (energy_valid_i),
        .energy_i        (energy_i),
        .spin_i          (spin_i),
        .energy_ready_o  (energy_ready_o),
        .src_push        (src_push)
    );

    spin_fifo_maintainer u_spin_fifo_maintainer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .en_i        (en_i),
        .flush_i     (flush_i),
        .fifo_push   (fifo_push),
        .pop_valid_o (pop_valid),
        .pop_spin_o  (pop_spin),
        .pop_ready_i (pop_ready)
    );

    flip_engine u_flip_engine (
        .clk_i                      (clk_i),
        .rst_n_i                    (rst_n_i),
        .en_i                       (en_i),
        .flush_i                    (flush_i),
        .cmpt_en_i                  (cmpt_en_i),
        .cmpt_idle_i                (cmpt_idle_o),
        .host_readout_i             (host_readout_i),
        .flip_disable_i             (flip_disable_i),
        .prev_valid_i               (pop_valid),
        .prev_spin_i                (pop_spin),
        .prev_ready_o               (pop_ready),
        .flipped_valid_o            (spin_pop_valid_o),
        .flipped_spin_o             (spin_pop_o),
        .flipped_ready_i            (spin_pop_ready_i),
        .flip_ren_o                 (flip_ren_o),
        .flip_raddr_o               (flip_raddr_o),
        .flip_rdata_i               (flip_rdata_i),
        .icon_last_raddr_plus_one_i (icon_last_raddr_plus_one_i),
        .icon_finish_o              (icon_finish)
    );

endmodule

`default_nettype wire

// ==== logic/flip_pkg.sv ====
/*
 * Sizes and shared types of the flip manager.
 * Icon addresses are one bit wider than an index so that "last plus one" fits.
 */
`default_nettype none

package flip_pkg;

    // Spin vector width and spin FIFO depth
    localparam int NUM_SPIN = 16;
    localparam int SPIN_DEPTH = 2;
    localparam int SPIN_PTR_BITS = (SPIN_DEPTH > 1) ? $clog2(SPIN_DEPTH) : 1;
    localparam int SPIN_CNT_BITS = $clog2(SPIN_DEPTH + 1);

    // Signed total energy
    localparam int ENERGY_BITS = 16;

    // Icon memory size and address width
    localparam int ICON_DEPTH = 8;
    localparam int ICON_ADDR_BITS = $clog2(ICON_DEPTH) + 1;

    typedef logic [NUM_SPIN-1:0] spin_t;
    typedef logic signed [ENERGY_BITS-1:0] energy_t;
    typedef logic [ICON_ADDR_BITS-1:0] icon_addr_t;

    // Start value of the best energy, most positive signed number
    localparam energy_t ENERGY_MAX = energy_t'({1'b0, {(ENERGY_BITS-1){1'b1}}});

    // Computation phase of the controller
    typedef enum logic [1:0] {
        CMPT_IDLE,
        CMPT_BUSY,
        CMPT_WAIT_LAST
    } cmpt_state_t;

endpackage

`default_nettype wire

// ==== logic/spin_fifo_maintainer.sv ====
/*
 * Circular spin FIFO of SPIN_DEPTH entries.
 * A none push stores a copy of the last spin pushed with none low.
 * A none push before any real push stores zeros.
 */
`timescale 1ns/1ps
`default_nettype none

module spin_fifo_maintainer (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            en_i,
    input  wire logic            flush_i,
    spin_push_if.sink            fifo_push,
    output logic                 pop_valid_o,
    output flip_pkg::spin_t      pop_spin_o,
    input  wire logic            pop_ready_i
);

    flip_pkg::spin_t mem_q [flip_pkg::SPIN_DEPTH];
    flip_pkg::spin_t last_spin_q;
    flip_pkg::spin_t wr_spin;
    logic [flip_pkg::SPIN_PTR_BITS-1:0] wr_ptr_q;
    logic [flip_pkg::SPIN_PTR_BITS-1:0] rd_ptr_q;
    logic [flip_pkg::SPIN_CNT_BITS-1:0] count_q;
    logic push_fire;
    logic pop_fire;

    assign fifo_push.ready = en_i & (count_q != flip_pkg::SPIN_CNT_BITS'(flip_pkg::SPIN_DEPTH));
    assign pop_valid_o = (count_q != '0);
    assign pop_spin_o = mem_q[rd_ptr_q];

    assign push_fire = fifo_push.valid & fifo_push.ready;
    assign pop_fire = pop_valid_o & pop_ready_i & en_i;

    // None expands to the last real spin
    assign wr_spin = fifo_push.none ? last_spin_q : fifo_push.spin;

    // Pointers, count and last real spin
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
            last_spin_q <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
            last_spin_q <= '0;
        end else if (en_i) begin
            if (push_fire) begin
                wr_ptr_q <= (wr_ptr_q == flip_pkg::SPIN_PTR_BITS'(flip_pkg::SPIN_DEPTH - 1)) ?
                            '0 : wr_ptr_q + 1'b1;
                if (!fifo_push.none) last_spin_q <= fifo_push.spin;
            end
            if (pop_fire) begin
                rd_ptr_q <= (rd_ptr_q == flip_pkg::SPIN_PTR_BITS'(flip_pkg::SPIN_DEPTH - 1)) ?
                            '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            if (push_fire && !pop_fire) begin
                count_q <= count_q + 1'b1;
            end else if (pop_fire && !push_fire) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_fire) begin
            mem_q[wr_ptr_q] <= wr_spin;
        end
    end

endmodule

`default_nettype wire

// ==== logic/spin_push_if.sv ====
/*
 * One spin push into the spin FIFO path.
 * Transfer on valid and ready; valid, spin and none hold until then.
 */
`timescale 1ns/1ps
`default_nettype none

interface spin_push_if;

    logic valid;
    flip_pkg::spin_t spin;
    // High means repeat the last real spin instead of spin
    logic none;
    logic ready;

    modport source (output valid, output spin, output none, input ready);

    modport sink (input valid, input spin, input none, output ready);

endinterface

`default_nettype wire

// ==== sim.f ====
logic/flip_pkg.sv
logic/spin_push_if.sv
logic/flip_controller.sv
logic/energy_fifo_maintainer.sv
logic/spin_fifo_maintainer.sv
logic/flip_engine.sv
logic/flip_manager.sv
verification/flip_manager_props.sv
verification/flip_manager_tb.sv

// ==== verification/flip_manager_props.sv ====
/*
 * Port level checks, bound to every flip_manager instance.
 */
`timescale 1ns/1ps
`default_nettype none

module flip_manager_props (
    input wire logic                 clk_i,
    input wire logic                 rst_n_i,
    input wire logic                 cmpt_idle_i,
    input wire logic                 flip_ren_i,
    input wire flip_pkg::icon_addr_t flip_raddr_i,
    input wire flip_pkg::icon_addr_t icon_last_i,
    input wire logic                 pop_valid_i,
    input wire logic                 pop_ready_i,
    input wire flip_pkg::spin_t      pop_spin_i
);

    // Icon reads stay inside the configured list
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flip_ren_i |-> (flip_raddr_i < icon_last_i))
        else $error("icon read beyond the last address");

    // Stalled output keeps its spin
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (pop_valid_i && !pop_ready_i) |=> (pop_valid_i && $stable(pop_spin_i)))
        else $error("stalled output changed");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(cmpt_idle_i && flip_ren_i))
        else $error("icon read while idle");

endmodule

bind flip_manager flip_manager_props u_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmpt_idle_i  (cmpt_idle_o),
    .flip_ren_i   (flip_ren_o),
    .flip_raddr_i (flip_raddr_o),
    .icon_last_i  (icon_last_raddr_plus_one_i),
    .pop_valid_i  (spin_pop_valid_o),
    .pop_ready_i  (spin_pop_ready_i),
    .pop_spin_i   (spin_pop_o)
);

`default_nettype wire

// ==== verification/flip_manager_tb.sv ====
/*
 * Testbench for flip_manager with icon memory and energy evaluator models.
 * The spin FIFO holds two entries, so each computation starts from two host spins.
 * Energy of a spin is its count of ones minus its count of zeros.
 */
`timescale 1ns/1ps
`default_nettype none

module flip_manager_tb;

    localparam int CLK_NS = 20;
    // Runs, outputs per run and worst cycles per output under back-pressure
    localparam int TIMEOUT_NS = 6 * flip_pkg::ICON_DEPTH * 64 * CLK_NS;

    logic clk_i;
    logic rst_n_i;
    logic en_i;
    logic flush_i;
    logic en_comparison_i;
    logic cmpt_en_i;
    logic cmpt_idle_o;
    logic host_readout_i;
    logic spin_configure_valid_i;
    flip_pkg::spin_t spin_configure_i;
    logic spin_configure_push_none_i;
    logic spin_configure_ready_o;
    logic spin_pop_valid_o;
    flip_pkg::spin_t spin_pop_o;
    logic spin_pop_ready_i;
    logic energy_valid_i;
    logic energy_ready_o;
    flip_pkg::energy_t energy_i;
    flip_pkg::spin_t spin_i;
    logic flip_ren_o;
    flip_pkg::icon_addr_t flip_raddr_o;
    flip_pkg::icon_addr_t icon_last_raddr_plus_one_i;
    flip_pkg::spin_t flip_rdata_i;
    logic flip_disable_i;

    // Icon memory contents and model state
    flip_pkg::spin_t icons [flip_pkg::ICON_DEPTH];
    flip_pkg::spin_t exp_q[$];
    flip_pkg::spin_t model_fifo[$];
    flip_pkg::spin_t energy_q[$];
    flip_pkg::spin_t model_last = '0;
    flip_pkg::spin_t last_read = '0;
    flip_pkg::spin_t hold_spin = '0;
    flip_pkg::energy_t model_best = '0;
    logic [31:0] lfsr = 32'd70156;
    logic bp_en = 1'b0;
    logic hold_pend = 1'b0;
    logic rd_pend = 1'b0;
    int rd_addr = 0;
    int n_out = 0;
    int n_energy = 0;
    int n_mismatch = 0;
    int n_other = 0;

    flip_manager dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    // Galois form with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic flip_pkg::spin_t rand_spin();
        flip_pkg::spin_t s;
        for (int i = 0; i < flip_pkg::NUM_SPIN; i++) begin
            lfsr = lfsr_next(lfsr);
            s[i] = lfsr[0];
        end
        return s;
    endfunction

    // Ones count minus zeros count
    function automatic flip_pkg::energy_t spin_energy(input flip_pkg::spin_t s);
        flip_pkg::energy_t e;
        e = '0;
        for (int i = 0; i < flip_pkg::NUM_SPIN; i++) begin
            e = s[i] ? e + flip_pkg::energy_t'(1) : e - flip_pkg::energy_t'(1);
        end
        return e;
    endfunction

    // Expected outputs of one computation; the FIFO model and best energy advance with it
    function automatic void predict_run(input logic cmp, input logic fdis, input int n_icon);
        flip_pkg::spin_t base;
        flip_pkg::spin_t flipped;
        flip_pkg::energy_t e;
        model_best = {1'b0, {(flip_pkg::ENERGY_BITS-1){1'b1}}};
        for (int k = 0; k < n_icon; k++) begin
            base = model_fifo.pop_front();
            flipped = fdis ? base : (base ^ icons[k]);
            exp_q.push_back(flipped);
            e = spin_energy(flipped);
            // Equal or higher energy repeats the last real spin
            if (cmp && !(e < model_best)) begin
                model_fifo.push_back(model_last);
            end else begin
                if (cmp) model_best = e;
                model_last = flipped;
                model_fifo.push_back(flipped);
            end
        end
    endfunction

    task automatic check_spin(input string what, input flip_pkg::spin_t got,
                              input flip_pkg::spin_t exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_energy(input string what, input flip_pkg::energy_t got,
                                input flip_pkg::energy_t exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // Host push starting on a falling edge
    task automatic configure(input flip_pkg::spin_t s, input logic none);
        spin_configure_valid_i = 1'b1;
        spin_configure_i = s;
        spin_configure_push_none_i = none;
        while (!spin_configure_ready_o) @(negedge clk_i);
        @(negedge clk_i);
        spin_configure_valid_i = 1'b0;
        if (!none) model_last = s;
        if (host_readout_i) exp_q.push_back(model_last);
        else model_fifo.push_back(model_last);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(posedge clk_i);
        @(negedge clk_i);
    endtask

    task automatic run_cmpt(input flip_pkg::spin_t s0, input flip_pkg::spin_t s1,
                            input logic cmp, input logic fdis, input int n_icon,
                            input logic bp);
        int out_base;
        int energy_base;
        configure(s0, 1'b0);
        configure(s1, 1'b0);
        en_comparison_i = cmp;
        flip_disable_i = fdis;
        icon_last_raddr_plus_one_i = flip_pkg::icon_addr_t'(n_icon);
        out_base = n_out;
        energy_base = n_energy;
        predict_run(cmp, fdis, n_icon);
        @(posedge clk_i);
        bp_en = bp;
        @(negedge clk_i);
        cmpt_en_i = 1'b1;
        @(negedge clk_i);
        cmpt_en_i = 1'b0;
        while (!cmpt_idle_o) @(negedge clk_i);
        check_flag("output count at idle", logic'(n_out - out_base == n_icon), 1'b1);
        check_flag("energy count at idle", logic'(n_energy - energy_base == n_icon), 1'b1);
        check_flag("all outputs seen", logic'(exp_q.size() == 0), 1'b1);
        // Read the FIFO back unflipped
        exp_q = model_fifo;
        model_fifo.delete();
        host_readout_i = 1'b1;
        wait_drained();
        host_readout_i = 1'b0;
        @(posedge clk_i);
        bp_en = 1'b0;
        @(negedge clk_i);
        // Last entry is the best spin or a copy of it
        if (cmp) check_energy("best energy", spin_energy(last_read), model_best);
    endtask

    // Icon memory, energy evaluator and output compare
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (rd_pend) flip_rdata_i = icons[rd_addr];
            rd_pend = flip_ren_o;
            rd_addr = int'(flip_raddr_o);
            if (energy_q.size() > 0) begin
                energy_valid_i = 1'b1;
                spin_i = energy_q[0];
                energy_i = spin_energy(energy_q[0]);
                if (energy_ready_o) begin
                    void'(energy_q.pop_front());
                    n_energy++;
                end
            end else begin
                energy_valid_i = 1'b0;
            end
            if (bp_en) begin
                lfsr = lfsr_next(lfsr);
                spin_pop_ready_i = lfsr[0];
            end else begin
                spin_pop_ready_i = 1'b1;
            end
            // Stalled output from the last cycle
            if (hold_pend) begin
                check_flag("held output valid", spin_pop_valid_o, 1'b1);
                check_spin("held output spin", spin_pop_o, hold_spin);
            end
            hold_pend = spin_pop_valid_o & ~spin_pop_ready_i;
            hold_spin = spin_pop_o;
            check_flag("icon read while idle", cmpt_idle_o & flip_ren_o, 1'b0);
            if (spin_pop_valid_o && spin_pop_ready_i) begin
                if (exp_q.size() == 0) begin
                    n_other++;
                    $display("Unexpected output %h at %0t", spin_pop_o, $time);
                end else begin
                    check_spin("output spin", spin_pop_o, exp_q.pop_front());
                end
                last_read = spin_pop_o;
                if (!cmpt_idle_o) begin
                    energy_q.push_back(spin_pop_o);
                    n_out++;
                end
            end
        end
    end

    initial begin
        flip_pkg::spin_t cfg_a;
        flip_pkg::spin_t cfg_b;
        flip_pkg::spin_t cfg_c;
        rst_n_i = 1'b0;
        en_i = 1'b1;
        flush_i = 1'b0;
        en_comparison_i = 1'b0;
        cmpt_en_i = 1'b0;
        host_readout_i = 1'b0;
        spin_configure_valid_i = 1'b0;
        spin_configure_i = '0;
        spin_configure_push_none_i = 1'b0;
        spin_pop_ready_i = 1'b0;
        energy_valid_i = 1'b0;
        energy_i = '0;
        spin_i = '0;
        icon_last_raddr_plus_one_i = '0;
        flip_rdata_i = '0;
        flip_disable_i = 1'b0;
        for (int i = 0; i < flip_pkg::ICON_DEPTH; i++) begin
            icons[i] = rand_spin();
        end
        repeat (4) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_flag("cmpt_idle_o after reset", cmpt_idle_o, 1'b1);
        check_flag("spin_pop_valid_o after reset", spin_pop_valid_o, 1'b0);
        check_flag("flip_ren_o after reset", flip_ren_o, 1'b0);
        check_flag("energy_ready_o after reset", energy_ready_o, 1'b0);
        check_flag("spin_configure_ready_o after reset", spin_configure_ready_o, 1'b1);
        // Streaming readout where the none entry repeats cfg_b
        cfg_a = rand_spin();
        cfg_b = rand_spin();
        cfg_c = rand_spin();
        host_readout_i = 1'b1;
        configure(cfg_a, 1'b0);
        configure(cfg_b, 1'b0);
        configure(cfg_c, 1'b1);
        configure(cfg_c, 1'b0);
        wait_drained();
        host_readout_i = 1'b0;
        cfg_a = rand_spin();
        cfg_b = rand_spin();
        run_cmpt(cfg_a, cfg_b, 1'b1, 1'b0, flip_pkg::ICON_DEPTH, 1'b0);
        run_cmpt(cfg_b, cfg_a, 1'b0, 1'b1, 5, 1'b0);
        run_cmpt(cfg_a, cfg_c, 1'b0, 1'b0, 6, 1'b1);
        // Same run as the first with a random ready
        run_cmpt(cfg_a, cfg_b, 1'b1, 1'b0, flip_pkg::ICON_DEPTH, 1'b1);
        $display("Errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
        if (n_mismatch + n_other == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
